/* cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// byte address width.
`define CACHE_ADDR_W 32

// one word per line.
`define CACHE_DATA_W 32

// direct mapped, one way.
`define CACHE_LINES 16
`define CACHE_INDEX_W 4

// two offset bits below the index.
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W - 2)

`endif

/* cache_pkg.sv */
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    typedef enum logic [1:0] {
        op_read  = 2'b00,
        op_write = 2'b01,
        op_flush = 2'b10
    } cpu_op_t;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]   tag;
        logic [`CACHE_INDEX_W-1:0] index;
        logic [1:0]                offset;
    } cache_addr_fields_t;

    // same address, flat or split into cache fields.
    typedef union packed {
        logic [`CACHE_ADDR_W-1:0] word;
        cache_addr_fields_t       fields;
    } cache_addr_u;

    typedef struct packed {
        cpu_op_t                  op;
        cache_addr_u              addr;
        logic [`CACHE_DATA_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                     valid;
        logic                     write;  // 1 for write-back, 0 for refill.
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

/* cpu_port.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module cpu_port import cache_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cpu_valid,
    input  cpu_req_t                 cpu_req,
    input  logic                     cache_ready,
    input  logic                     req_done,
    input  logic [`CACHE_DATA_W-1:0] line_data,
    output cpu_req_t                 cur_req,
    output logic                     cpu_rsp_valid,
    output logic [`CACHE_DATA_W-1:0] cpu_rdata
);

    // request latch, held until the next accepted request.
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cur_req <= '0;
        end else if (cpu_valid && cache_ready) begin
            cur_req <= cpu_req;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cpu_rsp_valid <= 1'b0;
        end else begin
            cpu_rsp_valid <= req_done;  // one pulse per request.
        end
    end

    always_ff @(posedge clk) begin
        if (req_done) begin
            cpu_rdata <= line_data;
        end
    end

endmodule

`default_nettype wire

/* cache_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_controller import cache_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    cpu_valid,
    input  cpu_op_t cpu_op,
    input  cpu_op_t req_op,
    input  logic    cache_hit,
    input  logic    dirty_bit,
    input  logic    flush_done,
    input  logic    axi_ack,
    output logic    cache_ready,
    output logic    req_done,
    output logic    change_dirty_bit,
    output logic    write_from_cpu,
    output logic    write_from_main_mem,
    output logic    flush_en,
    output logic    flush_count_en,
    output logic    read_req,
    output logic    write_req
);

    typedef enum logic [2:0] {
        st_idle            = 3'b000,
        st_process_request = 3'b001,
        st_allocate        = 3'b010,
        st_writeback       = 3'b011,
        st_flush           = 3'b100
    } state_t;

    state_t state, next_state;
    logic   flush_mode;  // write-back was entered from flush.

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state      <= st_idle;
            flush_mode <= 1'b0;
        end else begin
            state <= next_state;
            if (state == st_flush) begin
                flush_mode <= 1'b1;
            end else if (state == st_process_request) begin
                flush_mode <= 1'b0;
            end
        end
    end

    always_comb begin
        next_state          = state;
        cache_ready         = 1'b0;
        req_done            = 1'b0;
        change_dirty_bit    = 1'b0;
        write_from_cpu      = 1'b0;
        write_from_main_mem = 1'b0;
        flush_en            = 1'b0;
        flush_count_en      = 1'b0;
        read_req            = 1'b0;
        write_req           = 1'b0;

        case (state)
            st_idle: begin
                cache_ready = 1'b1;
                if (cpu_valid) begin
                    if (cpu_op == op_flush) begin
                        flush_en   = 1'b1;
                        next_state = st_flush;
                    end else begin
                        next_state = st_process_request;
                    end
                end
            end

            st_process_request: begin
                if (cache_hit && req_op == op_read) begin
                    req_done   = 1'b1;
                    next_state = st_idle;
                end else if (cache_hit && req_op == op_write) begin
                    write_from_cpu = 1'b1;
                    req_done       = 1'b1;
                    next_state     = st_idle;
                end else if (!cache_hit && !dirty_bit) begin
                    read_req   = 1'b1;
                    next_state = st_allocate;
                end else if (!cache_hit && dirty_bit) begin
                    write_req  = 1'b1;  // victim goes out first.
                    next_state = st_writeback;
                end
            end

            st_allocate: begin
                read_req = 1'b1;
                if (axi_ack) begin
                    change_dirty_bit    = 1'b1;
                    write_from_main_mem = 1'b1;
                    next_state          = st_process_request;  // retry, now hits.
                end
            end

            st_writeback: begin
                flush_en = flush_mode;
                if (axi_ack && flush_mode) begin
                    flush_count_en   = 1'b1;
                    change_dirty_bit = 1'b1;
                    next_state       = st_flush;
                end else if (axi_ack) begin
                    read_req   = 1'b1;
                    next_state = st_allocate;
                end
            end

            st_flush: begin
                flush_en = 1'b1;
                if (flush_done) begin
                    flush_en   = 1'b0;
                    req_done   = 1'b1;
                    next_state = st_idle;
                end else if (dirty_bit) begin
                    write_req  = 1'b1;
                    next_state = st_writeback;
                end else begin
                    flush_count_en = 1'b1;  // clean line, skip.
                end
            end

            default: next_state = st_idle;
        endcase
    end

endmodule

`default_nettype wire

/* cache_datapath.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module cache_datapath import cache_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_req_t                 cur_req,
    input  logic                     change_dirty_bit,
    input  logic                     write_from_cpu,
    input  logic                     write_from_main_mem,
    input  logic                     flush_en,
    input  logic                     flush_count_en,
    input  logic [`CACHE_DATA_W-1:0] refill_data,
    output logic                     cache_hit,
    output logic                     dirty_bit,
    output logic                     flush_done,
    output logic [`CACHE_DATA_W-1:0] line_data,
    output logic [`CACHE_TAG_W-1:0]  victim_tag,
    output logic [`CACHE_INDEX_W-1:0] active_index
);

    logic [`CACHE_DATA_W-1:0] data_mem [`CACHE_LINES];
    logic [`CACHE_TAG_W-1:0]  tag_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0]  valid_bits;
    logic [`CACHE_LINES-1:0]  dirty_bits;

    // one extra bit so the count can pass the last line.
    logic [`CACHE_INDEX_W:0]  flush_cnt;

    assign active_index = flush_en ? flush_cnt[`CACHE_INDEX_W-1:0]
                                   : cur_req.addr.fields.index;

    assign cache_hit  = valid_bits[active_index] &&
                        (tag_mem[active_index] == cur_req.addr.fields.tag);
    assign dirty_bit  = dirty_bits[active_index];
    assign line_data  = data_mem[active_index];
    assign victim_tag = tag_mem[active_index];
    assign flush_done = (flush_cnt == `CACHE_LINES);

    always_ff @(posedge clk) begin
        if (write_from_main_mem) begin
            data_mem[active_index] <= refill_data;
            tag_mem[active_index]  <= cur_req.addr.fields.tag;
        end else if (write_from_cpu) begin
            data_mem[active_index] <= cur_req.wdata;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            flush_cnt  <= '0;
        end else begin
            if (write_from_main_mem) begin
                valid_bits[active_index] <= 1'b1;
                dirty_bits[active_index] <= 1'b0;
            end else if (write_from_cpu) begin
                dirty_bits[active_index] <= 1'b1;
            end else if (flush_en && change_dirty_bit) begin
                dirty_bits[active_index] <= 1'b0;  // line now in memory.
            end

            // a flush also invalidates each line it leaves.
            if (flush_en && flush_count_en) begin
                valid_bits[active_index] <= 1'b0;
            end

            if (flush_count_en) begin
                flush_cnt <= flush_cnt + 1'b1;
            end else if (flush_done) begin
                flush_cnt <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* mem_port.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module mem_port import cache_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      read_req,
    input  logic                      write_req,
    input  cache_addr_u               req_addr,
    input  logic [`CACHE_TAG_W-1:0]   victim_tag,
    input  logic [`CACHE_INDEX_W-1:0] active_index,
    input  logic [`CACHE_DATA_W-1:0]  line_data,
    input  logic                      mem_ack,
    input  logic [`CACHE_DATA_W-1:0]  mem_rdata,
    output mem_req_t                  mem_req,
    output logic                      axi_ack,
    output logic [`CACHE_DATA_W-1:0]  refill_data
);

    cache_addr_u wr_addr;
    cache_addr_u rd_addr;

    always_comb begin
        wr_addr.fields.tag    = victim_tag;  // victim line address.
        wr_addr.fields.index  = active_index;
        wr_addr.fields.offset = 2'b00;
        rd_addr               = req_addr;
        rd_addr.fields.offset = 2'b00;
    end

    // valid stays up until the bus acknowledges.
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mem_req <= '0;
        end else if (mem_req.valid) begin
            if (mem_ack) begin
                mem_req.valid <= 1'b0;
            end
        end else if (write_req || read_req) begin
            mem_req.valid <= 1'b1;
            mem_req.write <= write_req;
            mem_req.addr  <= write_req ? wr_addr.word : rd_addr.word;
            mem_req.wdata <= line_data;
        end
    end

    assign axi_ack     = mem_ack && mem_req.valid;  // ignore stray acks.
    assign refill_data = mem_rdata;

endmodule

`default_nettype wire

/* cache_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module cache_top import cache_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cpu_valid,
    input  cpu_req_t                 cpu_req,
    output logic                     cache_ready,
    output logic                     cpu_rsp_valid,
    output logic [`CACHE_DATA_W-1:0] cpu_rdata,
    output mem_req_t                 mem_req,
    input  logic                     mem_ack,
    input  logic [`CACHE_DATA_W-1:0] mem_rdata
);

    cpu_req_t                  cur_req;
    logic                      req_done;
    logic                      cache_hit;
    logic                      dirty_bit;
    logic                      flush_done;
    logic                      axi_ack;
    logic                      change_dirty_bit;
    logic                      write_from_cpu;
    logic                      write_from_main_mem;
    logic                      flush_en;
    logic                      flush_count_en;
    logic                      read_req;
    logic                      write_req;
    logic [`CACHE_DATA_W-1:0]  line_data;
    logic [`CACHE_DATA_W-1:0]  refill_data;
    logic [`CACHE_TAG_W-1:0]   victim_tag;
    logic [`CACHE_INDEX_W-1:0] active_index;

    cpu_port cpu_port_i (
        .clk           (clk),
        .reset         (reset),
        .cpu_valid     (cpu_valid),
        .cpu_req       (cpu_req),
        .cache_ready   (cache_ready),
        .req_done      (req_done),
        .line_data     (line_data),
        .cur_req       (cur_req),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rdata     (cpu_rdata)
    );

    cache_controller cache_controller_i (
        .clk                 (clk),
        .reset               (reset),
        .cpu_valid           (cpu_valid),
        .cpu_op              (cpu_req.op),  // live op, only looked at in idle.
        .req_op              (cur_req.op),
        .cache_hit           (cache_hit),
        .dirty_bit           (dirty_bit),
        .flush_done          (flush_done),
        .axi_ack             (axi_ack),
        .cache_ready         (cache_ready),
        .req_done            (req_done),
        .change_dirty_bit    (change_dirty_bit),
        .write_from_cpu      (write_from_cpu),
        .write_from_main_mem (write_from_main_mem),
        .flush_en            (flush_en),
        .flush_count_en      (flush_count_en),
        .read_req            (read_req),
        .write_req           (write_req)
    );

    cache_datapath cache_datapath_i (
        .clk                 (clk),
        .reset               (reset),
        .cur_req             (cur_req),
        .change_dirty_bit    (change_dirty_bit),
        .write_from_cpu      (write_from_cpu),
        .write_from_main_mem (write_from_main_mem),
        .flush_en            (flush_en),
        .flush_count_en      (flush_count_en),
        .refill_data         (refill_data),
        .cache_hit           (cache_hit),
        .dirty_bit           (dirty_bit),
        .flush_done          (flush_done),
        .line_data           (line_data),
        .victim_tag          (victim_tag),
        .active_index        (active_index)
    );

    mem_port mem_port_i (
        .clk          (clk),
        .reset        (reset),
        .read_req     (read_req),
        .write_req    (write_req),
        .req_addr     (cur_req.addr),
        .victim_tag   (victim_tag),
        .active_index (active_index),
        .line_data    (line_data),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .mem_req      (mem_req),
        .axi_ack      (axi_ack),
        .refill_data  (refill_data)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD = 20  // ns, so a 40 ns period.
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

/* tb_cache.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module tb_cache import cache_pkg::*; ();

    localparam int NUM_RANDOM   = 60;
    localparam int MAX_REQUESTS = NUM_RANDOM + 30;  // random phase plus directed ones.
    localparam int RSP_LIMIT    = 400;

    logic                     clk;
    logic                     reset;
    logic                     cpu_valid;
    cpu_req_t                 cpu_req;
    logic                     cache_ready;
    logic                     cpu_rsp_valid;
    logic [`CACHE_DATA_W-1:0] cpu_rdata;
    mem_req_t                 mem_req;
    logic                     mem_ack;
    logic [`CACHE_DATA_W-1:0] mem_rdata;

    logic [31:0] model_mem [logic [31:0]];  // expected contents by word address.
    logic [31:0] mem_words [logic [31:0]];  // sparse responder memory.
    bit          xfer_write [$];
    logic [31:0] xfer_addr [$];
    logic [31:0] xfer_data [$];
    int          mem_xfers;
    int          mem_writes;
    int          errors;
    int          test_start_errors;
    int          tests_passed;
    int          tests_failed;
    string       test_name;

    tb_clock_gen clock_gen_i (.clk(clk));

    cache_top dut_i (.*);

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h6b3c_a591;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return mem_words.exists(addr) ? mem_words[addr] : fill_word(addr);
    endfunction

    // untouched words read as the fill pattern.
    function automatic logic [31:0] model_read(input logic [31:0] addr);
        if (!model_mem.exists(addr)) begin
            model_mem[addr] = fill_word(addr);
        end
        return model_mem[addr];
    endfunction

    // three tags over four lines, so conflicts are common.
    function automatic logic [31:0] pool_addr();
        logic [`CACHE_TAG_W-1:0]   tag;
        logic [`CACHE_INDEX_W-1:0] idx;
        tag = 26'h0004c0 + 26'($urandom_range(0, 2));
        idx = 4'($urandom_range(0, 3));
        return {tag, idx, 2'b00};
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = errors;
    endtask

    task automatic finish_test();
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - test_start_errors);
        end
    endtask

    // called at a falling edge with the cache idle.
    task automatic run_request(input cpu_op_t op, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output int edges);
        int waited;
        if (!cache_ready) begin
            $display("%s: cache not ready for a new request", test_name);
            errors++;
        end
        cpu_req.op        = op;
        cpu_req.addr.word = addr;
        cpu_req.wdata     = wdata;
        cpu_valid         = 1'b1;
        @(posedge clk);
        edges = 1;  // the accepting edge.
        @(negedge clk);
        cpu_valid = 1'b0;
        waited    = 0;
        while (!cpu_rsp_valid && waited < RSP_LIMIT) begin
            @(negedge clk);
            edges++;
            waited++;
        end
        if (!cpu_rsp_valid) begin
            $display("%s: no response from the cache within %0d cycles", test_name, RSP_LIMIT);
            errors++;
        end
        rdata = cpu_rdata;
    endtask

    // memory responder answers each request after 0 to 5 cycles.
    initial begin
        int delay;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            mem_ack = 1'b0;
            if (mem_req.valid) begin
                delay = $urandom_range(0, 5);
                repeat (delay) @(negedge clk);
                xfer_write.push_back(mem_req.write);
                xfer_addr.push_back(mem_req.addr);
                xfer_data.push_back(mem_req.wdata);
                mem_xfers++;
                if (mem_req.write) begin
                    mem_words[mem_req.addr] = mem_req.wdata;
                    mem_writes++;
                end else begin
                    mem_rdata = mem_word(mem_req.addr);
                end
                mem_ack = 1'b1;
            end
        end
    end

    // about 200 cycles per request at most.
    initial begin
        repeat (MAX_REQUESTS * 200) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", MAX_REQUESTS * 200);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] other;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] touched [$];
        int          edges;
        int          xfers_before;
        int          writes_before;
        cpu_op_t     op;

        void'($urandom(32'haf664e38));
        reset     = 1'b0;
        cpu_valid = 1'b0;
        cpu_req   = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        @(negedge clk);

        start_test("reset_state");
        check("cache_ready", 32'd1, 32'(cache_ready));
        check("mem_req valid", 32'd0, 32'(mem_req.valid));
        check("cpu_rsp_valid", 32'd0, 32'(cpu_rsp_valid));
        finish_test();

        start_test("random_rw");
        for (int i = 0; i < NUM_RANDOM; i++) begin
            addr  = pool_addr();
            wdata = $urandom();
            op    = ($urandom_range(0, 1) == 1) ? op_write : op_read;
            run_request(op, addr, wdata, rdata, edges);
            if (op == op_write) begin
                model_mem[addr] = wdata;
            end else begin
                check("read data", model_read(addr), rdata);
            end
        end
        finish_test();

        start_test("read_hit");
        addr = pool_addr();
        run_request(op_read, addr, '0, rdata, edges);
        check("first read data", model_read(addr), rdata);
        xfers_before = mem_xfers;
        run_request(op_read, addr, '0, rdata, edges);
        check("hit latency in edges", 32'd2, edges);
        check("memory requests", 32'(xfers_before), 32'(mem_xfers));
        check("mem_req valid", 32'd0, 32'(mem_req.valid));
        check("hit read data", model_read(addr), rdata);
        finish_test();

        // line 5 is outside the random pool.
        start_test("conflict_evict");
        addr  = {26'h0001a7, 4'd5, 2'b00};
        other = {26'h0002b9, 4'd5, 2'b00};
        wdata = $urandom();
        run_request(op_write, addr, wdata, rdata, edges);
        model_mem[addr] = wdata;
        xfer_write.delete();
        xfer_addr.delete();
        xfer_data.delete();
        run_request(op_read, other, '0, rdata, edges);
        check("transfer count", 32'd2, xfer_addr.size());
        if (xfer_addr.size() == 2) begin
            check("first is write-back", 32'd1, 32'(xfer_write[0]));
            check("write-back address", addr, xfer_addr[0]);
            check("write-back data", wdata, xfer_data[0]);
            check("second is refill", 32'd0, 32'(xfer_write[1]));
            check("refill address", other, xfer_addr[1]);
        end
        check("read data", model_read(other), rdata);
        finish_test();

        start_test("flush");
        run_request(op_flush, '0, '0, rdata, edges);
        foreach (model_mem[a]) begin
            touched.push_back(a);
        end
        foreach (touched[i]) begin
            check("memory after flush", model_mem[touched[i]], mem_word(touched[i]));
        end
        foreach (touched[i]) begin
            xfers_before  = mem_xfers;
            writes_before = mem_writes;
            run_request(op_read, touched[i], '0, rdata, edges);
            check("read after flush", model_read(touched[i]), rdata);
            check("write-backs after flush", 32'(writes_before), 32'(mem_writes));
            check("read missed", 32'd1, 32'(mem_xfers > xfers_before));
        end
        finish_test();

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
cache_pkg.sv
cpu_port.sv
cache_controller.sv
cache_datapath.sv
mem_port.sv
cache_top.sv
tb_clock_gen.sv
tb_cache.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cache
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
